/* branch_predictor.f */
logic/bp_pkg.sv
logic/lookup_pipe.sv
logic/btb_table.sv
logic/gshare_pht.sv
logic/predict_select.sv
logic/branch_predictor.sv
testbench/tb_branch_predictor.sv

/* testbench/tb_branch_predictor.sv */
// Self-checking testbench for the branch predictor, run as top module against a model of its tables
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor
    import bp_pkg::*;
;

    localparam int BTB_ENTRIES     = 32;
    localparam int GHR_BITS        = 8;
    localparam int BTB_IDX_W       = $clog2(BTB_ENTRIES);
    localparam int PHT_ENTRIES     = 1 << GHR_BITS;
    localparam int DIRECTED_CYCLES = 150;
    localparam int RAND_STEPS      = 350;
    // Four times the stimulus length is ample margin for a healthy run
    localparam int MAX_CYCLES      = 4 * (DIRECTED_CYCLES + RAND_STEPS);
    localparam logic [XLEN-1:0] IDLE_PC = 32'h0000_0f00;

    logic            clk;
    logic            reset_i;
    logic [XLEN-1:0] pc_i;
    logic            fetch_valid_i;
    logic            stall_i;
    logic            flush_i;
    logic            ghr_clear_i;
    logic            upd_valid_i;
    logic [OP_W-1:0] upd_op_i;
    logic            upd_taken_i;
    logic [XLEN-1:0] upd_target_i;
    logic            pred_taken_o;
    logic [XLEN-1:0] next_pc_o;

    // Reference state of the tables and the two-stage pipe
    logic [XLEN-1:0]     m_btb_tag    [BTB_ENTRIES];
    logic [XLEN-1:0]     m_btb_target [BTB_ENTRIES];
    logic [KIND_W-1:0]   m_btb_kind   [BTB_ENTRIES];
    logic                m_btb_valid  [BTB_ENTRIES];
    logic [CTR_W-1:0]    m_pht        [PHT_ENTRIES];
    logic [GHR_BITS-1:0] m_ghr;
    logic                m_dec_valid;
    logic                m_exe_valid;
    logic [XLEN-1:0]     m_dec_pc;
    logic [XLEN-1:0]     m_exe_pc;
    logic [GHR_BITS-1:0] m_dec_idx;
    logic [GHR_BITS-1:0] m_exe_idx;

    logic [GHR_BITS-1:0]  exp_idx;
    logic [BTB_IDX_W-1:0] exp_btb_idx;
    logic                 exp_hit;
    logic                 exp_taken;
    logic [XLEN-1:0]      exp_next_pc;
    logic [31:0]          lfsr_state;
    int                   cycle_count = 0;
    int                   taken_cycles = 0;

    branch_predictor #(
        .NUM_BTB_ENTRIES(BTB_ENTRIES),
        .NUM_GHR_BITS   (GHR_BITS)
    ) branch_predictor_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .fetch_valid_i(fetch_valid_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .ghr_clear_i  (ghr_clear_i),
        .upd_valid_i  (upd_valid_i),
        .upd_op_i     (upd_op_i),
        .upd_taken_i  (upd_taken_i),
        .upd_target_i (upd_target_i),
        .pred_taken_o (pred_taken_o),
        .next_pc_o    (next_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected prediction for the PC presented this cycle
    always_comb begin
        exp_idx     = pc_i[GHR_BITS+1:2] ^ m_ghr;
        exp_btb_idx = pc_i[BTB_IDX_W+1:2];
        exp_hit     = m_btb_valid[exp_btb_idx] && (m_btb_tag[exp_btb_idx] == pc_i);
        exp_taken   = 1'b0;
        if (exp_hit && (m_btb_kind[exp_btb_idx] == KIND_JUMP)) begin
            exp_taken = 1'b1;
        end else if (exp_hit && (m_btb_kind[exp_btb_idx] == KIND_BRANCH)) begin
            exp_taken = m_pht[exp_idx][CTR_W-1];
        end
        exp_next_pc = exp_taken ? m_btb_target[exp_btb_idx] : pc_i + 32'd4;
    end

    // Model training, pipe movement and history
    always @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                m_btb_valid[i] <= 1'b0;
                m_btb_tag[i]   <= '0;
                m_btb_kind[i]  <= KIND_NONE;
            end
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                m_pht[i] <= CTR_INIT;
            end
            m_ghr       <= '0;
            m_dec_valid <= 1'b0;
            m_exe_valid <= 1'b0;
        end else begin
            if (upd_valid_i && m_exe_valid) begin
                if ((upd_op_i == OP_JAL) || (upd_op_i == OP_JALR) ||
                    ((upd_op_i == OP_BRANCH) && upd_taken_i)) begin
                    m_btb_valid[m_exe_pc[BTB_IDX_W+1:2]]  <= 1'b1;
                    m_btb_tag[m_exe_pc[BTB_IDX_W+1:2]]    <= m_exe_pc;
                    m_btb_target[m_exe_pc[BTB_IDX_W+1:2]] <= upd_target_i;
                    m_btb_kind[m_exe_pc[BTB_IDX_W+1:2]]   <=
                        (upd_op_i == OP_BRANCH) ? KIND_BRANCH : KIND_JUMP;
                end
                if (upd_op_i == OP_BRANCH) begin
                    if (upd_taken_i && (m_pht[m_exe_idx] != 2'd3)) begin
                        m_pht[m_exe_idx] <= m_pht[m_exe_idx] + 2'd1;
                    end else if (!upd_taken_i && (m_pht[m_exe_idx] != 2'd0)) begin
                        m_pht[m_exe_idx] <= m_pht[m_exe_idx] - 2'd1;
                    end
                end
            end
            if (ghr_clear_i) begin
                m_ghr <= '0;
            end else if (upd_valid_i && m_exe_valid && (upd_op_i == OP_BRANCH)) begin
                m_ghr <= {upd_taken_i, m_ghr[GHR_BITS-1:1]};
            end
            if (flush_i) begin
                m_dec_valid <= 1'b0;
                m_exe_valid <= 1'b0;
            end else if (!stall_i) begin
                m_dec_valid <= fetch_valid_i;
                m_exe_valid <= m_dec_valid;
            end
            if (!stall_i) begin
                if (fetch_valid_i) begin
                    m_dec_pc  <= pc_i;
                    m_dec_idx <= exp_idx;
                end
                m_exe_pc  <= m_dec_pc;
                m_exe_idx <= m_dec_idx;
            end
        end
    end

    a_taken_matches: assert property (@(posedge clk) disable iff (reset_i)
        pred_taken_o === exp_taken)
    else begin
        $display("[FAIL] %0t pred_taken_o=%b expected %b for pc %h", $time,
                 $sampled(pred_taken_o), $sampled(exp_taken), $sampled(pc_i));
        $display("tests failed");
        $fatal(1);
    end

    a_next_pc_matches: assert property (@(posedge clk) disable iff (reset_i)
        next_pc_o === exp_next_pc)
    else begin
        $display("[FAIL] %0t next_pc_o=%h expected %h for pc %h", $time,
                 $sampled(next_pc_o), $sampled(exp_next_pc), $sampled(pc_i));
        $display("tests failed");
        $fatal(1);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset_i && exp_taken) begin
            taken_cycles <= taken_cycles + 1;
        end
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $fatal(1);
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // One cycle of stimulus, driven just after the rising edge
    task automatic step(input logic [XLEN-1:0] pc, input logic fv, input logic stall,
                        input logic flush, input logic clr, input logic uv,
                        input logic [OP_W-1:0] op, input logic taken,
                        input logic [XLEN-1:0] target);
        @(posedge clk);
        pc_i          <= pc;
        fetch_valid_i <= fv;
        stall_i       <= stall;
        flush_i       <= flush;
        ghr_clear_i   <= clr;
        upd_valid_i   <= uv;
        upd_op_i      <= op;
        upd_taken_i   <= taken;
        upd_target_i  <= target;
    endtask

    task automatic idle();
        step(IDLE_PC, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic lookup(input logic [XLEN-1:0] pc);
        step(pc, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic clear_history();
        step(IDLE_PC, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, '0, 1'b0, '0);
    endtask

    // Fetch, let it reach execute, then report its outcome
    task automatic resolve(input logic [XLEN-1:0] pc, input logic [OP_W-1:0] op,
                           input logic taken, input logic [XLEN-1:0] target);
        lookup(pc);
        idle();
        step(IDLE_PC, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, op, taken, target);
    endtask

    // Each pass starts from an empty history so the same counter trains
    task automatic train_branch(input logic [XLEN-1:0] pc, input logic taken, input int passes);
        for (int p = 0; p < passes; p++) begin
            clear_history();
            resolve(pc, OP_BRANCH, taken, 32'h0000_0600);
        end
        clear_history();
        lookup(pc);
    endtask

    function automatic logic [OP_W-1:0] pick_op(input logic [1:0] sel);
        case (sel)
            2'd2:    return OP_JAL;
            2'd3:    return OP_JALR;
            default: return OP_BRANCH;
        endcase
    endfunction

    initial begin
        logic [31:0] r_pc;
        logic [31:0] r_tgt;
        logic [31:0] r_ctl;

        lfsr_state    = 32'hb3810b52;
        reset_i       = 1'b1;
        pc_i          = '0;
        fetch_valid_i = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        ghr_clear_i   = 1'b0;
        upd_valid_i   = 1'b0;
        upd_op_i      = '0;
        upd_taken_i   = 1'b0;
        upd_target_i  = '0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        // Empty tables fall through everywhere
        for (int n = 0; n < 8; n++) begin
            draw_bits(30, r_pc);
            lookup({r_pc[29:0], 2'b00});
        end

        // JAL allocates and stays taken across history changes
        resolve(32'h0000_0100, OP_JAL, 1'b1, 32'h0000_0400);
        lookup(32'h0000_0100);
        resolve(32'h0000_0140, OP_BRANCH, 1'b1, 32'h0000_0500);
        lookup(32'h0000_0100);

        // Counter walk including saturation at both ends
        train_branch(32'h0000_0200, 1'b1, 2);
        train_branch(32'h0000_0200, 1'b0, 2);
        train_branch(32'h0000_0200, 1'b0, 3);
        train_branch(32'h0000_0200, 1'b1, 5);
        train_branch(32'h0000_0200, 1'b0, 2);

        // Alias at the same BTB index, then replacement
        lookup(32'h0000_0180);
        resolve(32'h0000_0180, OP_JALR, 1'b1, 32'h0000_0800);
        lookup(32'h0000_0100);
        lookup(32'h0000_0180);

        // Update while stalled hits the PC held in execute
        lookup(32'h0000_0300);
        idle();
        step(32'h0000_03f0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        step(IDLE_PC, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, OP_JAL, 1'b1, 32'h0000_0900);
        idle();
        lookup(32'h0000_0300);

        // Flush together with stall still empties the pipe
        lookup(32'h0000_0340);
        idle();
        step(IDLE_PC, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
        step(IDLE_PC, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, OP_JAL, 1'b1, 32'h0000_0a00);
        idle();
        lookup(32'h0000_0340);

        // Random traffic over 64 PCs, so entries alias and histories vary
        for (int n = 0; n < RAND_STEPS; n++) begin
            draw_bits(6, r_pc);
            draw_bits(8, r_tgt);
            draw_bits(16, r_ctl);
            step(32'h0000_1000 | {r_pc[5:0], 2'b00}, 1'b1, r_ctl[6:4] == 3'd0,
                 r_ctl[10:7] == 4'd0, r_ctl[15:11] == 5'd0, r_ctl[0],
                 pick_op(r_ctl[3:2]), r_ctl[1], 32'h0000_2000 | {r_tgt[7:0], 2'b00});
        end
        repeat (3) idle();
        @(posedge clk);

        if (taken_cycles == 0) begin
            $display("Stimulus never produced a taken prediction to compare");
            $display("tests failed");
            $fatal(1);
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* logic/branch_predictor.sv */
// Branch prediction unit top level, giving a same-cycle next-PC guess and training from execute
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
    import bp_pkg::*;
#(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 8
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            fetch_valid_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            ghr_clear_i,
    input  logic            upd_valid_i,
    input  logic [OP_W-1:0] upd_op_i,
    input  logic            upd_taken_i,
    input  logic [XLEN-1:0] upd_target_i,
    output logic            pred_taken_o,
    output logic [XLEN-1:0] next_pc_o
);

    logic [NUM_GHR_BITS-1:0] pht_index;
    logic                    counter_msb;
    logic                    btb_hit;
    logic [KIND_W-1:0]       btb_kind;
    logic [XLEN-1:0]         btb_target;
    logic                    exe_update;
    logic [XLEN-1:0]         exe_pc;
    logic [NUM_GHR_BITS-1:0] exe_pht_index;

    lookup_pipe #(
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) lookup_pipe_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_valid_i  (fetch_valid_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .pc_i           (pc_i),
        .pht_index_i    (pht_index),
        .upd_valid_i    (upd_valid_i),
        .exe_update_o   (exe_update),
        .exe_pc_o       (exe_pc),
        .exe_pht_index_o(exe_pht_index)
    );

    btb_table #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)
    ) btb_table_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .update_i    (exe_update),
        .upd_pc_i    (exe_pc),
        .upd_op_i    (upd_op_i),
        .upd_taken_i (upd_taken_i),
        .upd_target_i(upd_target_i),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target)
    );

    gshare_pht #(
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) gshare_pht_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .ghr_clear_i  (ghr_clear_i),
        .update_i     (exe_update),
        .upd_op_i     (upd_op_i),
        .upd_taken_i  (upd_taken_i),
        .upd_index_i  (exe_pht_index),
        .pht_index_o  (pht_index),
        .counter_msb_o(counter_msb)
    );

    predict_select predict_select_inst (
        .pc_i         (pc_i),
        .hit_i        (btb_hit),
        .kind_i       (btb_kind),
        .target_i     (btb_target),
        .counter_msb_i(counter_msb),
        .pred_taken_o (pred_taken_o),
        .next_pc_o    (next_pc_o)
    );

endmodule

`default_nettype wire

/* logic/predict_select.sv */
// Next-PC selection from the BTB lookup and the gshare counter of the current fetch PC
`timescale 1ns/1ps
`default_nettype none

module predict_select
    import bp_pkg::*;
(
    input  logic [XLEN-1:0]   pc_i,
    input  logic              hit_i,
    input  logic [KIND_W-1:0] kind_i,
    input  logic [XLEN-1:0]   target_i,
    input  logic              counter_msb_i,
    output logic              pred_taken_o,
    output logic [XLEN-1:0]   next_pc_o
);

    // Jumps are always taken, branches follow the counter
    always_comb begin
        pred_taken_o = 1'b0;
        if (hit_i) begin
            if (kind_i == KIND_JUMP) begin
                pred_taken_o = 1'b1;
            end else if (kind_i == KIND_BRANCH) begin
                pred_taken_o = counter_msb_i;
            end
        end
    end

    // Fall through to the next sequential instruction
    assign next_pc_o = pred_taken_o ? target_i : pc_i + XLEN'(4);

endmodule

`default_nettype wire

/* logic/gshare_pht.sv */
// Gshare direction predictor with the global history register and 2-bit counter table
`timescale 1ns/1ps
`default_nettype none

module gshare_pht
    import bp_pkg::*;
#(
    parameter int NUM_GHR_BITS = 8
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [XLEN-1:0]         pc_i,
    input  logic                    ghr_clear_i,
    input  logic                    update_i,
    input  logic [OP_W-1:0]         upd_op_i,
    input  logic                    upd_taken_i,
    input  logic [NUM_GHR_BITS-1:0] upd_index_i,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    output logic                    counter_msb_o
);

    localparam int PHT_ENTRIES = 1 << NUM_GHR_BITS;

    logic [NUM_GHR_BITS-1:0] ghr;
    logic [CTR_W-1:0]        pht [PHT_ENTRIES];
    logic [CTR_W-1:0]        upd_ctr;
    logic                    pht_we;

    // Word address of the fetch PC hashed with the history
    assign pht_index_o   = pc_i[NUM_GHR_BITS+1:2] ^ ghr;
    assign counter_msb_o = pht[pht_index_o][CTR_W-1];

    // Only conditional branches train direction
    assign pht_we  = update_i && (upd_op_i == OP_BRANCH);
    assign upd_ctr = pht[upd_index_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= CTR_INIT;
            end
        end else if (pht_we) begin
            if (upd_taken_i && (upd_ctr != CTR_MAX)) begin
                pht[upd_index_i] <= upd_ctr + 1'b1;
            end else if (!upd_taken_i && (upd_ctr != '0)) begin
                pht[upd_index_i] <= upd_ctr - 1'b1;
            end
        end
    end

    // Newest outcome enters at the MSB, clear beats the shift
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr <= '0;
        end else if (pht_we) begin
            ghr <= {upd_taken_i, ghr[NUM_GHR_BITS-1:1]};
        end
    end

    // Counters never wrap around at either end
    a_sat_up: assert property (@(posedge clk) disable iff (reset_i)
        pht_we && upd_taken_i |=> pht[$past(upd_index_i)] >= $past(upd_ctr));

    a_sat_down: assert property (@(posedge clk) disable iff (reset_i)
        pht_we && !upd_taken_i |=> pht[$past(upd_index_i)] <= $past(upd_ctr));

endmodule

`default_nettype wire

/* logic/btb_table.sv */
// Direct-mapped branch target buffer, looked up by the fetch PC and written from execute
`timescale 1ns/1ps
`default_nettype none

module btb_table
    import bp_pkg::*;
#(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic              update_i,
    input  logic [XLEN-1:0]   upd_pc_i,
    input  logic [OP_W-1:0]   upd_op_i,
    input  logic              upd_taken_i,
    input  logic [XLEN-1:0]   upd_target_i,
    output logic              hit_o,
    output logic [KIND_W-1:0] kind_o,
    output logic [XLEN-1:0]   target_o
);

    localparam int IDX_W = $clog2(NUM_BTB_ENTRIES);

    logic [XLEN-1:0]            tag_q    [NUM_BTB_ENTRIES];
    logic [XLEN-1:0]            target_q [NUM_BTB_ENTRIES];
    logic [KIND_W-1:0]          kind_q   [NUM_BTB_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic              is_jump;
    logic              is_branch;
    logic              wr_en;
    logic [KIND_W-1:0] wr_kind;

    // Word aligned PCs, so the index starts at bit 2
    assign rd_idx = pc_i[IDX_W+1:2];
    assign wr_idx = upd_pc_i[IDX_W+1:2];

    // Jumps always allocate, branches only once seen taken
    always_comb begin
        is_jump   = (upd_op_i == OP_JAL) || (upd_op_i == OP_JALR);
        is_branch = (upd_op_i == OP_BRANCH);
        wr_en     = update_i && (is_jump || (is_branch && upd_taken_i));
        wr_kind   = is_jump ? KIND_JUMP : KIND_BRANCH;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // A new write replaces the old entry at that index
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= upd_pc_i;
            target_q[wr_idx] <= upd_target_i;
            kind_q[wr_idx]   <= wr_kind;
        end
    end

    // Full PC as tag, so aliasing PCs never hit
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == pc_i);
    assign kind_o   = kind_q[rd_idx];
    assign target_o = target_q[rd_idx];

    a_write_has_kind: assert property (@(posedge clk) disable iff (reset_i)
        wr_en |=> valid_q[$past(wr_idx)] && (kind_q[$past(wr_idx)] != KIND_NONE));

endmodule

`default_nettype wire

/* logic/lookup_pipe.sv */
// Decode and execute stage registers that carry each fetched PC and its PHT index to training
`timescale 1ns/1ps
`default_nettype none

module lookup_pipe
    import bp_pkg::*;
#(
    parameter int NUM_GHR_BITS = 8
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    fetch_valid_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic [XLEN-1:0]         pc_i,
    input  logic [NUM_GHR_BITS-1:0] pht_index_i,
    input  logic                    upd_valid_i,
    output logic                    exe_update_o,
    output logic [XLEN-1:0]         exe_pc_o,
    output logic [NUM_GHR_BITS-1:0] exe_pht_index_o
);

    logic                    dec_valid;
    logic [XLEN-1:0]         dec_pc;
    logic [NUM_GHR_BITS-1:0] dec_pht_index;
    logic                    exe_valid;
    logic [XLEN-1:0]         exe_pc;
    logic [NUM_GHR_BITS-1:0] exe_pht_index;

    // Flush wins over stall for the valid bits
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            dec_valid <= 1'b0;
            exe_valid <= 1'b0;
        end else if (!stall_i) begin
            dec_valid <= fetch_valid_i;
            exe_valid <= dec_valid;
        end
    end

    // PC and index move one stage per unstalled edge
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            if (fetch_valid_i) begin
                dec_pc        <= pc_i;
                dec_pht_index <= pht_index_i;
            end
            exe_pc        <= dec_pc;
            exe_pht_index <= dec_pht_index;
        end
    end

    // The only place where a resolved outcome is qualified
    assign exe_update_o    = upd_valid_i && exe_valid;
    assign exe_pc_o        = exe_pc;
    assign exe_pht_index_o = exe_pht_index;

    // A stalled stage keeps whatever live content it holds
    a_stall_holds: assert property (@(posedge clk) disable iff (reset_i)
        stall_i && !flush_i |=>
            $stable({dec_valid, exe_valid}) &&
            (!dec_valid || $stable({dec_pc, dec_pht_index})) &&
            (!exe_valid || $stable({exe_pc, exe_pht_index})));

endmodule

`default_nettype wire

/* logic/bp_pkg.sv */
// Shared widths, RV32 opcodes and table encodings, imported by every block of the branch predictor
`default_nettype none

package bp_pkg;

    // Address and opcode field widths
    localparam int XLEN = 32;
    localparam int OP_W = 7;

    // RV32 opcodes of the control transfer instructions the unit learns
    localparam logic [OP_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OP_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OP_W-1:0] OP_JALR   = 7'b1100111;

    // Saturating direction counter whose MSB predicts taken
    localparam int               CTR_W    = 2;
    localparam logic [CTR_W-1:0] CTR_INIT = 2'b00;
    localparam logic [CTR_W-1:0] CTR_MAX  = 2'b11;

    // Kind of control transfer held in a BTB entry
    localparam int                KIND_W      = 2;
    localparam logic [KIND_W-1:0] KIND_NONE   = 2'd0;
    localparam logic [KIND_W-1:0] KIND_BRANCH = 2'd1;
    localparam logic [KIND_W-1:0] KIND_JUMP   = 2'd2;

endpackage

`default_nettype wire
